// ==== build.f ====
hdl/alu_pkg.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/alu_master.sv
test/alu_master_assert.sv
test/alu_tb.sv

// ==== hdl/alu_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_master import alu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  alu_op_e     aluop,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [31:0] cp0_data,
    input  hilo_word_t  hilo,
    output logic        stall,
    output logic [31:0] y,
    output hilo_word_t  hilo_out,
    output logic        overflow
);

    md_req_t     req;
    logic        mul_start;
    logic        div_start;
    hilo_word_t  mul_res;
    hilo_word_t  div_res;
    logic        mul_ready;
    logic        div_ready;
    logic [31:0] sum;
    logic [31:0] diff;

    // one-entry cache of the last finished long op
    logic        last_valid;
    alu_op_e     last_op;
    logic [31:0] last_a;
    logic [31:0] last_b;
    hilo_word_t  last_result;
    logic        cache_hit;

    function automatic logic [31:0] lead_count(input logic [31:0] v, input logic ones);
        logic [31:0] n;
        logic        run;
        n   = '0;
        run = 1'b1;
        for (int i = 31; i >= 0; i--) begin
            if (run && (v[i] == ones)) begin
                n = n + 1;
            end else begin
                run = 1'b0;
            end
        end
        return n;
    endfunction

    assign sum  = a + b;
    assign diff = a - b;

    assign req.a         = a;
    assign req.b         = b;
    assign req.is_signed = (aluop == MULT) || (aluop == DIV);

    assign cache_hit = last_valid && (last_op == aluop) && (last_a == a) && (last_b == b);

    always_comb begin
        y         = '0;
        hilo_out  = '0;
        overflow  = 1'b0;
        stall     = 1'b0;
        mul_start = 1'b0;
        div_start = 1'b0;
        case (aluop)
            ADD: begin
                y        = sum;
                overflow = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            ADDU: y = sum;
            SUB: begin
                y        = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            SUBU: y = diff;
            SLT:  y = {31'd0, $signed(a) < $signed(b)};
            SLTU: y = {31'd0, a < b};
            CLO:  y = lead_count(a, 1'b1);
            CLZ:  y = lead_count(a, 1'b0);
            AND:  y = a & b;
            OR:   y = a | b;
            NOR:  y = ~(a | b);
            XOR:  y = a ^ b;
            LUI:  y = {b[15:0], 16'd0};
            SLL:  y = b << a[4:0];
            SRL:  y = b >> a[4:0];
            SRA:  y = $signed(b) >>> a[4:0];
            MULT, MULTU: begin
                // ready wins over a stale hit on the same op
                if (mul_ready) begin
                    hilo_out = mul_res;
                end else if (cache_hit) begin
                    hilo_out = last_result;
                end else begin
                    mul_start = 1'b1;
                    stall     = 1'b1;
                end
                y = hilo_out.prod[31:0];
            end
            DIV, DIVU: begin
                if (div_ready) begin
                    hilo_out = div_res;
                end else if (cache_hit) begin
                    hilo_out = last_result;
                end else begin
                    div_start = 1'b1;
                    stall     = 1'b1;
                end
            end
            MTHI: hilo_out.prod = {a, hilo.prod[31:0]};
            MTLO: hilo_out.prod = {hilo.prod[63:32], a};
            MFHI: y = hilo.prod[63:32];
            MFLO: y = hilo.prod[31:0];
            MFC0: y = cp0_data;
            default: y = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_valid <= 1'b0;
        end else if ((mul_ready || div_ready) && is_md_op(aluop)) begin
            last_valid <= 1'b1;
        end
    end

    // op is still held at the inputs when ready pulses
    always_ff @(posedge clk) begin
        if ((mul_ready || div_ready) && is_md_op(aluop)) begin
            last_op     <= aluop;
            last_a      <= a;
            last_b      <= b;
            last_result <= mul_ready ? mul_res : div_res;
        end
    end

    mul_unit u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (mul_start),
        .req    (req),
        .result (mul_res),
        .ready  (mul_ready)
    );

    div_unit u_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (div_start),
        .req    (req),
        .result (div_res),
        .ready  (div_ready)
    );

endmodule

`default_nettype wire

// ==== hdl/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // accept edge plus 31 more steps, then one sign-fix edge
    localparam int MD_CYCLES = 33;
    localparam int MD_CNT_W  = $clog2(MD_CYCLES);

    // codes follow the MIPS funct field where one exists
    typedef enum logic [7:0] {
        SLL   = 8'h00,
        SRL   = 8'h02,
        SRA   = 8'h03,
        MFHI  = 8'h10,
        MTHI  = 8'h11,
        MFLO  = 8'h12,
        MTLO  = 8'h13,
        MULT  = 8'h18,
        MULTU = 8'h19,
        DIV   = 8'h1a,
        DIVU  = 8'h1b,
        ADD   = 8'h20,
        ADDU  = 8'h21,
        SUB   = 8'h22,
        SUBU  = 8'h23,
        AND   = 8'h24,
        OR    = 8'h25,
        XOR   = 8'h26,
        NOR   = 8'h27,
        SLT   = 8'h2a,
        SLTU  = 8'h2b,
        LUI   = 8'h4f,   // opcode 0x0f moved clear of funct space
        CLZ   = 8'h60,
        CLO   = 8'h61,
        MFC0  = 8'h80
    } alu_op_e;

    // request handed to either engine
    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic        is_signed;
    } md_req_t;

    typedef struct packed {
        logic [31:0] rem;    // HI
        logic [31:0] quo;    // LO
    } hilo_qr_t;

    // multiplier fills prod, divider fills qr
    typedef union packed {
        logic [63:0] prod;
        hilo_qr_t    qr;
    } hilo_word_t;

    function automatic logic is_md_op(input alu_op_e op);
        return op inside {MULT, MULTU, DIV, DIVU};
    endfunction

endpackage

`default_nettype wire

// ==== hdl/div_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_unit import alu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  md_req_t    req,
    output hilo_word_t result,
    output logic       ready
);

    logic                busy;
    logic [MD_CNT_W-1:0] cnt;
    logic                accept;
    logic                last_step;
    logic                qneg;
    logic                rneg;
    logic [31:0]         divisor;
    logic [63:0]         rq;       // partial remainder above quotient
    logic [31:0]         mag_a;
    logic [31:0]         mag_b;

    // restoring step shifts in the next dividend bit and subtracts if it fits
    function automatic logic [63:0] div_step(input logic [63:0] rq_in,
                                             input logic [31:0] dvs);
        logic [32:0] part;
        logic [32:0] diff;
        logic [63:0] nxt;
        part = rq_in[63:31];
        diff = part - {1'b0, dvs};
        if (diff[32]) begin
            nxt = {part[31:0], rq_in[30:0], 1'b0};
        end else begin
            nxt = {diff[31:0], rq_in[30:0], 1'b1};
        end
        return nxt;
    endfunction

    assign mag_a     = (req.is_signed && req.a[31]) ? -req.a : req.a;
    assign mag_b     = (req.is_signed && req.b[31]) ? -req.b : req.b;
    assign accept    = start && !busy;
    assign last_step = (cnt == MD_CNT_W'(MD_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            cnt   <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= MD_CNT_W'(1);
            end else if (busy) begin
                if (last_step) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // divide by zero gives an all-ones quotient and the dividend as remainder
    always_ff @(posedge clk) begin
        if (accept) begin
            divisor <= mag_b;
            qneg    <= req.is_signed && (req.a[31] ^ req.b[31]);
            rneg    <= req.is_signed && req.a[31];   // follows dividend
            rq      <= div_step({32'd0, mag_a}, mag_b);
        end else if (busy) begin
            if (last_step) begin
                result.qr.quo <= qneg ? -rq[31:0] : rq[31:0];
                result.qr.rem <= rneg ? -rq[63:32] : rq[63:32];
            end else begin
                rq <= div_step(rq, divisor);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mul_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit import alu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  md_req_t    req,
    output hilo_word_t result,
    output logic       ready
);

    logic                busy;
    logic [MD_CNT_W-1:0] cnt;
    logic                accept;
    logic                last_step;
    logic                neg;
    logic [31:0]         mcand;
    logic [63:0]         acc;
    logic [31:0]         mag_a;
    logic [31:0]         mag_b;

    // one shift-add step with multiplier bits leaving at the bottom
    function automatic logic [63:0] mul_step(input logic [63:0] acc_in,
                                             input logic [31:0] m);
        logic [32:0] sum;
        sum = {1'b0, acc_in[63:32]} + (acc_in[0] ? {1'b0, m} : 33'd0);
        return {sum, acc_in[31:1]};
    endfunction

    assign mag_a     = (req.is_signed && req.a[31]) ? -req.a : req.a;
    assign mag_b     = (req.is_signed && req.b[31]) ? -req.b : req.b;
    assign accept    = start && !busy;    // start ignored while running
    assign last_step = (cnt == MD_CNT_W'(MD_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            cnt   <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= MD_CNT_W'(1);
            end else if (busy) begin
                if (last_step) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // first step already happens on the accept edge
    always_ff @(posedge clk) begin
        if (accept) begin
            mcand <= mag_a;
            neg   <= req.is_signed && (req.a[31] ^ req.b[31]);
            acc   <= mul_step({32'd0, mag_b}, mag_a);
        end else if (busy) begin
            if (last_step) begin
                result.prod <= neg ? -acc : acc;
            end else begin
                acc <= mul_step(acc, mcand);
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module alu_tb -f build.f -o alu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/alu_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
    exit 1
fi
exit 0

// ==== test/alu_master_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_master_assert import alu_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input alu_op_e aluop,
    input logic    stall,
    input logic    overflow,
    input logic    mul_ready,
    input logic    div_ready
);

    int         fail_cnt = 0;   // read by the testbench summary
    logic [7:0] stall_run;      // stall cycles seen so far in this run

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_run <= '0;
        end else if (stall) begin
            stall_run <= stall_run + 1'b1;
        end else begin
            stall_run <= '0;
        end
    end

    short_op_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !is_md_op(aluop) |-> !stall)
        else begin
            $error("stall raised on single-cycle opcode %s", aluop.name());
            fail_cnt++;
        end

    mul_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mul_ready |=> !mul_ready)
        else begin
            $error("multiplier ready held longer than one cycle");
            fail_cnt++;
        end

    div_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        div_ready |=> !div_ready)
        else begin
            $error("divider ready held longer than one cycle");
            fail_cnt++;
        end

    stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> stall_run < 8'(MD_CYCLES))
        else begin
            $error("stall high for more than the engine latency");
            fail_cnt++;
        end

    ovf_only_add_sub: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |-> (aluop == ADD || aluop == SUB))
        else begin
            $error("overflow raised on %s", aluop.name());
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== test/alu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_tb import alu_pkg::*; ();

    logic        clk;
    logic        rst_n;
    alu_op_e     aluop;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] cp0_data;
    hilo_word_t  hilo;
    logic        stall;
    logic [31:0] y;
    hilo_word_t  hilo_out;
    logic        overflow;

    int errors;
    int checks;
    int seed;

    // expected state of the one-entry result cache
    logic        c_valid;
    alu_op_e     c_op;
    logic [31:0] c_a;
    logic [31:0] c_b;

    alu_op_e single_ops [21] = '{ADD, ADDU, SUB, SUBU, SLT, SLTU, CLO, CLZ, AND, OR, NOR,
                                 XOR, LUI, SLL, SRL, SRA, MTHI, MTLO, MFHI, MFLO, MFC0};
    alu_op_e long_ops [4] = '{MULT, MULTU, DIV, DIVU};
    logic [31:0] corners [5] = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff};

    alu_master DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .aluop    (aluop),
        .a        (a),
        .b        (b),
        .cp0_data (cp0_data),
        .hilo     (hilo),
        .stall    (stall),
        .y        (y),
        .hilo_out (hilo_out),
        .overflow (overflow)
    );

    bind alu_master alu_master_assert u_assert (
        .clk       (clk),
        .rst_n     (rst_n),
        .aluop     (aluop),
        .stall     (stall),
        .overflow  (overflow),
        .mul_ready (mul_ready),
        .div_ready (div_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int lead_ones(input logic [31:0] v);
        int n;
        n = 0;
        while (n < 32 && v[31 - n]) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic [31:0] ref_y(input alu_op_e op, input logic [31:0] x,
                                          input logic [31:0] z, input hilo_word_t hl,
                                          input logic [31:0] c0);
        logic [31:0] r;
        case (op)
            ADD, ADDU: r = x + z;
            SUB, SUBU: r = x - z;
            SLT:       r = (int'(x) < int'(z)) ? 32'd1 : 32'd0;
            SLTU:      r = (x < z) ? 32'd1 : 32'd0;
            CLO:       r = 32'(lead_ones(x));
            CLZ:       r = 32'(lead_ones(~x));
            AND:       r = x & z;
            OR:        r = x | z;
            NOR:       r = ~(x | z);
            XOR:       r = x ^ z;
            LUI:       r = z << 16;
            SLL:       r = z << x[4:0];
            SRL:       r = z >> x[4:0];
            SRA:       r = $signed(z) >>> x[4:0];
            MFHI:      r = hl.prod[63:32];
            MFLO:      r = hl.prod[31:0];
            MFC0:      r = c0;
            default:   r = '0;
        endcase
        return r;
    endfunction

    // signed overflow from a 33-bit sign-extended result
    function automatic logic ref_ovf(input alu_op_e op, input logic [31:0] x,
                                     input logic [31:0] z);
        logic [32:0] s;
        if (op == ADD) begin
            s = {x[31], x} + {z[31], z};
        end else if (op == SUB) begin
            s = {x[31], x} - {z[31], z};
        end else begin
            return 1'b0;
        end
        return s[32] != s[31];
    endfunction

    function automatic hilo_word_t ref_md(input alu_op_e op, input logic [31:0] x,
                                          input logic [31:0] z);
        hilo_word_t r;
        longint     sx;
        longint     sz;
        if (op == MULT || op == DIV) begin
            sx = longint'($signed(x));
            sz = longint'($signed(z));
        end else begin
            sx = longint'(x);
            sz = longint'(z);
        end
        if (op == MULT || op == MULTU) begin
            r.prod = sx * sz;
        end else if (z == 32'd0) begin
            // all-ones magnitude with the normal quotient sign
            r.qr.quo = (op == DIV && x[31]) ? -32'hffffffff : 32'hffffffff;
            r.qr.rem = x;
        end else begin
            r.qr.quo = 32'(sx / sz);    // truncating so rem follows the dividend
            r.qr.rem = 32'(sx % sz);
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_run();
        int asserts;
        asserts = DUT.u_assert.fail_cnt;
        $display("checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic drive(input alu_op_e op, input logic [31:0] x, input logic [31:0] z);
        @(negedge clk);
        aluop    = op;
        a        = x;
        b        = z;
        cp0_data = $random(seed);
        hilo     = {$random(seed), $random(seed)};
        #1;    // decode settles well before the next rising edge
    endtask

    task automatic run_single(input alu_op_e op, input logic [31:0] x, input logic [31:0] z);
        hilo_word_t exp_hl;
        drive(op, x, z);
        check_val($sformatf("%s stall", op.name()), 64'(stall), 64'd0);
        if (op == MTHI || op == MTLO) begin
            exp_hl = hilo;
            if (op == MTHI) begin
                exp_hl.prod[63:32] = x;
            end else begin
                exp_hl.prod[31:0] = x;
            end
            check_val($sformatf("%s hilo_out", op.name()), hilo_out.prod, exp_hl.prod);
        end else begin
            check_val($sformatf("%s y", op.name()), 64'(y),
                      64'(ref_y(op, x, z, hilo, cp0_data)));
            check_val($sformatf("%s overflow", op.name()), 64'(overflow),
                      64'(ref_ovf(op, x, z)));
        end
    endtask

    task automatic run_long(input alu_op_e op, input logic [31:0] x, input logic [31:0] z);
        hilo_word_t exp_hl;
        int         cycles;
        int         exp_cycles;
        exp_hl     = ref_md(op, x, z);
        exp_cycles = (c_valid && c_op == op && c_a == x && c_b == z) ? 0 : MD_CYCLES;
        drive(op, x, z);
        cycles = 0;
        while (stall) begin
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > MD_CYCLES + 4) begin
                $display("timeout: stall stuck high on %s after %0d cycles", op.name(), cycles);
                errors++;
                end_run();
            end
        end
        check_val($sformatf("%s stall cycles", op.name()), 64'(cycles), 64'(exp_cycles));
        check_val($sformatf("%s hilo_out", op.name()), hilo_out.prod, exp_hl.prod);
        check_val($sformatf("%s y", op.name()), 64'(y),
                  (op == MULT || op == MULTU) ? 64'(exp_hl.prod[31:0]) : 64'd0);
        c_valid = 1'b1;
        c_op    = op;
        c_a     = x;
        c_b     = z;
    endtask

    initial begin
        int idx;
        seed     = 51;
        errors   = 0;
        checks   = 0;
        c_valid  = 1'b0;
        rst_n    = 1'b0;
        aluop    = ADD;
        a        = '0;
        b        = '0;
        cp0_data = '0;
        hilo     = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (single_ops[i]) begin
            foreach (corners[j]) begin
                foreach (corners[k]) begin
                    run_single(single_ops[i], corners[j], corners[k]);
                end
            end
        end
        repeat (300) begin
            idx = {$random(seed)} % 21;
            run_single(single_ops[idx], $random(seed), $random(seed));
        end

        foreach (long_ops[i]) begin
            foreach (corners[j]) begin
                foreach (corners[k]) begin
                    run_long(long_ops[i], corners[j], corners[k]);
                end
            end
        end
        repeat (40) begin
            idx = {$random(seed)} % 4;
            run_long(long_ops[idx], $random(seed), $random(seed));
        end

        // cache hits on a held and a re-presented op, then one operand changed
        run_long(MULT, 32'hfffffff3, 32'h00012345);
        run_long(MULT, 32'hfffffff3, 32'h00012345);
        run_single(XOR, 32'h1, 32'h2);
        run_long(MULT, 32'hfffffff3, 32'h00012345);
        run_long(MULT, 32'hfffffff3, 32'h00012346);
        run_long(DIV, 32'h80000000, 32'h00000007);
        run_single(MFC0, 32'h0, 32'h0);
        run_long(DIV, 32'h80000000, 32'h00000007);
        run_long(DIV, 32'h80000001, 32'h00000007);

        end_run();
    end

endmodule

`default_nettype wire
